/* arch_state.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module arch_state (
    input  logic                          clk,
    input  logic                          rst_n,
    wb_commit_if.state                    commit_if,
    input  logic [$clog2(`WB_NREGS)-1:0]  gpr_rd_addr,
    input  logic [$clog2(`WB_NREGS)-1:0]  seg_rd_addr,
    output logic [`WB_DATA_W-1:0]         gpr_rd_data,
    output logic [`WB_SEG_W-1:0]          seg_rd_data,
    output logic [`WB_ADDR_W-1:0]         eip,
    output logic [`WB_SEG_W-1:0]          cs,
    output logic [`WB_EFLAGS_W-1:0]       eflags,
    output logic                          halted
);

    logic [`WB_DATA_W-1:0] gpr [`WB_NREGS];
    logic [`WB_SEG_W-1:0]  seg [`WB_NREGS];

    // four write ports per file; later slots override earlier ones
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `WB_NREGS; r++) begin
                gpr[r] <= '0;
                seg[r] <= '0;
            end
        end else begin
            for (int s = 0; s < `WB_SLOTS; s++) begin
                if (commit_if.reg_ld[s])
                    gpr[commit_if.idx[s]] <= commit_if.data[s];
                if (commit_if.seg_ld[s])
                    seg[commit_if.idx[s]] <= commit_if.data[s][`WB_SEG_W-1:0];  // low 16 bits
            end
        end
    end

    // EIP, CS and flags move only when an instruction retires
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eip    <= '0;
            cs     <= '0;
            eflags <= '0;
        end else if (commit_if.commit) begin
            eip    <= commit_if.new_eip;
            eflags <= commit_if.eflags;
            if (commit_if.ld_cs)
                cs <= commit_if.new_cs;  // far jmp/call/iret
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n)
            halted <= 1'b0;
        else if (commit_if.halt_set)
            halted <= 1'b1;
    end

    // asynchronous read ports
    assign gpr_rd_data = gpr[gpr_rd_addr];
    assign seg_rd_data = seg[seg_rd_addr];

endmodule

/* flist.f */
+incdir+.
wb_pkg.sv
wb_ifs.sv
writeback_stage.sv
arch_state.sv
wb_store_queue.sv
wb_top.sv
tb_wb.sv

/* tb_wb.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module tb_wb;
    import wb_pkg::*;

    localparam int ACK_RAND   = 0;
    localparam int ACK_LOW    = 1;
    localparam int ACK_HIGH   = 2;
    localparam int ACK_SPARSE = 3;

    logic clk;
    logic rst_n;
    logic valid_in;
    wb_op_e op;
    logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0] slot_data;
    logic [`WB_SLOTS-1:0][`WB_ADDR_W-1:0] slot_dest;
    slot_kind_e [`WB_SLOTS-1:0] slot_kind;
    logic [`WB_SLOTS-1:0] slot_wb;
    logic [1:0] op_size;
    logic [3:0] size_ovr;
    logic [`WB_ADDR_W-1:0] eip_in;
    logic [`WB_EFLAGS_W-1:0] eflags_in;
    logic br_valid, br_taken, br_correct;
    logic [`WB_ADDR_W-1:0] br_target;
    logic ie_in, interrupt_in;
    ie_type_e ie_type_in;
    logic [2:0] gpr_rd_addr, seg_rd_addr;
    logic st_ack;
    logic valid_out, stall, is_resteer, ie_val;
    logic [3:0] ie_type_out;
    logic [`WB_DATA_W-1:0] gpr_rd_data;
    logic [`WB_SEG_W-1:0] seg_rd_data;
    logic [`WB_ADDR_W-1:0] eip;
    logic [`WB_SEG_W-1:0] cs;
    logic [`WB_EFLAGS_W-1:0] eflags;
    logic halted, st_valid;
    logic [`WB_ADDR_W-1:0] st_addr;
    logic [`WB_DATA_W-1:0] st_data;
    logic [1:0] st_size;

    // reference model
    logic [`WB_DATA_W-1:0] m_gpr [`WB_NREGS];
    logic [`WB_SEG_W-1:0]  m_seg [`WB_NREGS];
    logic [`WB_ADDR_W-1:0] m_eip;
    logic [`WB_SEG_W-1:0]  m_cs;
    logic [`WB_EFLAGS_W-1:0] m_eflags;
    logic m_halted;
    logic [`WB_ADDR_W-1:0] mq_addr [$];
    logic [`WB_DATA_W-1:0] mq_data [$];
    logic [1:0]            mq_size [$];

    logic [15:0] lfsr_state;
    logic held;        // inputs frozen by a stall
    logic force_mem;   // slot 0 always a memory write
    logic allow_halt;
    string cur_test;
    int n_checks, n_errors, test_err0, n_tests, n_passed, waited;

    wb_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #100000;
        $display("timeout: simulation ran past its time limit");
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch %s %s: expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
        end
    endtask

    task automatic new_instr();
        logic [2:0] r;
        logic [2:0] ov;
        valid_in <= (take_bits(2) != 0) || force_mem;
        r = 3'(take_bits(3));
        if (r >= 3'd5)
            op <= wb_op_e'(r - 3'd3);  // far jmp, far call, iret
        else if (r == 3'd1 && allow_halt)
            op <= op_halt;
        else
            op <= op_normal;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            slot_kind[i] <= (force_mem && i == 0) ? sk_mem : slot_kind_e'(take_bits(2));
            slot_wb[i]   <= (force_mem && i == 0) ? 1'b1 : 1'(take_bits(1));
            slot_dest[i] <= 32'(take_bits(32));
            slot_data[i] <= take_bits(64);
        end
        ov = 3'(take_bits(3));
        size_ovr     <= ov[2] ? (4'b0001 << ov[1:0]) : 4'b0000;
        op_size      <= 2'(take_bits(2));
        eip_in       <= 32'(take_bits(32));
        eflags_in    <= 18'(take_bits(18));
        br_valid     <= 1'(take_bits(1));
        br_taken     <= 1'(take_bits(1));
        br_correct   <= 1'(take_bits(1));
        br_target    <= 32'(take_bits(32));
        ie_in        <= (take_bits(2) == 0);
        ie_type_in   <= ie_type_e'(take_bits(3));
        interrupt_in <= (take_bits(2) == 0);
    endtask

    task automatic check_cycle();
        logic far;
        logic has_mem;
        logic e_stall;
        logic e_commit;
        logic [1:0] sz;
        int mem_sel;
        mem_sel = -1;
        far = (op == op_far_jmp) || (op == op_far_call) || (op == op_iret);
        // state left by earlier commits
        check("gpr_rd_data", m_gpr[gpr_rd_addr], gpr_rd_data);
        check("seg_rd_data", m_seg[seg_rd_addr], seg_rd_data);
        check("eip", m_eip, eip);
        check("cs", m_cs, cs);
        check("eflags", m_eflags, eflags);
        check("halted", m_halted, halted);
        for (int i = 0; i < `WB_SLOTS; i++)
            if (slot_wb[i] && slot_kind[i] == sk_mem && mem_sel < 0)
                mem_sel = i;
        has_mem  = valid_in && (mem_sel >= 0);
        e_stall  = has_mem && (mq_addr.size() == `WB_SQ_DEPTH);
        e_commit = valid_in && !e_stall;
        check("stall", e_stall, stall);
        check("valid_out", e_commit, valid_out);
        check("is_resteer", e_commit && br_valid && !br_correct, is_resteer);
        check("ie_val", valid_in && (ie_in || interrupt_in), ie_val);
        check("ie_type_out", valid_in ? {interrupt_in, ie_type_in} : 4'd0, ie_type_out);
        check("st_valid", mq_addr.size() != 0, st_valid);
        if (st_ack && mq_addr.size() != 0) begin
            check("st_addr", mq_addr.pop_front(), st_addr);
            check("st_data", mq_data.pop_front(), st_data);
            check("st_size", mq_size.pop_front(), st_size);
        end
        if (e_commit) begin
            for (int i = 0; i < `WB_SLOTS; i++) begin  // later slot overwrites
                if (slot_wb[i] && slot_kind[i] == sk_reg)
                    m_gpr[slot_dest[i][2:0]] = slot_data[i];
                if (slot_wb[i] && slot_kind[i] == sk_seg)
                    m_seg[slot_dest[i][2:0]] = slot_data[i][15:0];
            end
            if (!br_taken)
                m_eip = eip_in;
            else
                m_eip = far ? slot_data[0][31:0] : br_target;
            if (far)
                m_cs = slot_data[0][47:32];
            m_eflags = eflags_in;
            if (op == op_halt)
                m_halted = 1'b1;
            if (mem_sel >= 0) begin
                if (size_ovr != 4'b0000) begin
                    for (int j = 0; j < 4; j++)
                        if (size_ovr[j])
                            sz = 2'(j);
                end else begin
                    sz = far ? 2'd3 : op_size;
                end
                mq_addr.push_back(slot_dest[mem_sel]);
                mq_data.push_back(slot_data[mem_sel]);
                mq_size.push_back(sz);
            end
        end
        held = e_stall;
    endtask

    task automatic drive_cycle(input int ack_mode);
        @(posedge clk);
        if (!held)
            new_instr();
        gpr_rd_addr <= 3'(take_bits(3));
        seg_rd_addr <= 3'(take_bits(3));
        case (ack_mode)
            ACK_LOW:    st_ack <= 1'b0;
            ACK_HIGH:   st_ack <= 1'b1;
            ACK_SPARSE: st_ack <= (take_bits(2) == 0);
            default:    st_ack <= 1'(take_bits(1));
        endcase
        @(negedge clk);
        check_cycle();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n    <= 1'b0;
        valid_in <= 1'b0;
        st_ack   <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < `WB_NREGS; r++) begin
            m_gpr[r] = '0;
            m_seg[r] = '0;
        end
        m_eip = '0;
        m_cs = '0;
        m_eflags = '0;
        m_halted = 1'b0;
        mq_addr.delete();
        mq_data.delete();
        mq_size.delete();
        held = 1'b0;
        @(negedge clk);
        check("halted after reset", 0, halted);
        check("st_valid after reset", 0, st_valid);
        check("stall after reset", 0, stall);
        check("valid_out after reset", 0, valid_out);
        check("eip after reset", 0, eip);
        check("cs after reset", 0, cs);
        check("eflags after reset", 0, eflags);
        check("gpr after reset", 0, gpr_rd_data);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err0 = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        if (n_errors == test_err0) begin
            n_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, n_errors - test_err0);
        end
    endtask

    initial begin
        lfsr_state = 16'd35465;
        rst_n = 1'b0;
        valid_in = 1'b0;
        op = op_normal;
        slot_data = '0;
        slot_dest = '0;
        for (int i = 0; i < `WB_SLOTS; i++)
            slot_kind[i] = sk_none;
        slot_wb = '0;
        op_size = '0;
        size_ovr = '0;
        eip_in = '0;
        eflags_in = '0;
        br_valid = 1'b0;
        br_taken = 1'b0;
        br_correct = 1'b0;
        br_target = '0;
        ie_in = 1'b0;
        ie_type_in = ie_divide;
        interrupt_in = 1'b0;
        gpr_rd_addr = '0;
        seg_rd_addr = '0;
        st_ack = 1'b0;
        held = 1'b0;
        force_mem = 1'b0;
        allow_halt = 1'b0;
        start_test("reset");
        apply_reset();
        end_test();

        start_test("reg_seg_commit");
        repeat (300) drive_cycle(ACK_RAND);
        end_test();

        start_test("store_path");
        repeat (300) drive_cycle(ACK_SPARSE);  // queue often full
        end_test();

        start_test("back_pressure");
        force_mem = 1'b1;
        waited = 0;
        while (!stall && waited < 32) begin
            drive_cycle(ACK_LOW);
            waited++;
        end
        if (!stall) begin
            n_errors++;
            $display("back_pressure: stall never rose with the ack held low");
        end
        repeat (4) drive_cycle(ACK_LOW);  // instruction held while stalled
        if (!stall) begin
            n_errors++;
            $display("back_pressure: stall dropped although nothing was acked");
        end
        force_mem = 1'b0;
        waited = 0;
        while (stall && waited < 32) begin
            drive_cycle(ACK_HIGH);
            waited++;
        end
        if (stall) begin
            n_errors++;
            $display("back_pressure: stall did not clear while the queue was drained");
        end
        end_test();

        start_test("eip_cs");
        repeat (200) drive_cycle(ACK_RAND);
        end_test();

        start_test("ie_halt");
        allow_halt = 1'b1;
        repeat (200) drive_cycle(ACK_RAND);
        apply_reset();  // halted must clear
        end_test();

        $display("tests %0d, passed %0d, checks %0d, errors %0d",
                 n_tests, n_passed, n_checks, n_errors);
        if (n_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// result data and address widths
`define WB_DATA_W    64
`define WB_ADDR_W    32

// result slots carried by one instruction
`define WB_SLOTS     4

// general and segment register files, 3-bit index
`define WB_NREGS     8

// pending memory writes
`define WB_SQ_DEPTH  4

// architectural register widths
`define WB_SEG_W     16
`define WB_EFLAGS_W  18

`endif

/* wb_ifs.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

// register, segment and control commits into the architectural state
interface wb_commit_if;
    localparam int IDX_W = $clog2(`WB_NREGS);

    logic [`WB_SLOTS-1:0]                  reg_ld;
    logic [`WB_SLOTS-1:0]                  seg_ld;
    logic [`WB_SLOTS-1:0][IDX_W-1:0]       idx;     // per-slot destination index
    logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0]  data;
    logic                                  commit;  // instruction retires this cycle
    logic [`WB_ADDR_W-1:0]                 new_eip;
    logic                                  ld_cs;
    logic [`WB_SEG_W-1:0]                  new_cs;
    logic [`WB_EFLAGS_W-1:0]               eflags;
    logic                                  halt_set;

    modport stage (
        output reg_ld, seg_ld, idx, data, commit,
        output new_eip, ld_cs, new_cs, eflags, halt_set
    );

    modport state (
        input reg_ld, seg_ld, idx, data, commit,
        input new_eip, ld_cs, new_cs, eflags, halt_set
    );
endinterface

// memory write handed to the writeback address queue
interface wb_store_if;
    logic                   push;  // one-cycle strobe, never while full
    logic [`WB_ADDR_W-1:0]  addr;
    logic [`WB_DATA_W-1:0]  data;
    logic [1:0]             size;
    logic                   full;

    modport stage (
        output push, addr, data, size,
        input  full
    );

    modport queue (
        input  push, addr, data, size,
        output full
    );
endinterface

/* wb_pkg.sv */
package wb_pkg;

    // instruction class seen at writeback
    typedef enum logic [2:0] {
        op_normal   = 3'd0,
        op_halt     = 3'd1,
        op_far_jmp  = 3'd2,  // loads EIP:CS
        op_far_call = 3'd3,  // loads EIP:CS
        op_iret     = 3'd4   // loads EIP:CS
    } wb_op_e;

    // where a result slot goes
    typedef enum logic [1:0] {
        sk_none = 2'd0,
        sk_reg  = 2'd1,
        sk_seg  = 2'd2,
        sk_mem  = 2'd3
    } slot_kind_e;

    // exception class reported with ie_val
    typedef enum logic [2:0] {
        ie_divide     = 3'd0,
        ie_debug      = 3'd1,
        ie_breakpoint = 3'd2,
        ie_overflow   = 3'd3,
        ie_bound      = 3'd4,
        ie_invalid_op = 3'd5,
        ie_gen_prot   = 3'd6,
        ie_page_fault = 3'd7
    } ie_type_e;

endpackage

/* wb_store_queue.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_store_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    wb_store_if.queue              store_if,
    input  logic                   st_ack,   // pops the head
    output logic                   st_valid,
    output logic [`WB_ADDR_W-1:0]  st_addr,
    output logic [`WB_DATA_W-1:0]  st_data,
    output logic [1:0]             st_size
);

    localparam int DEPTH = `WB_SQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`WB_ADDR_W-1:0] addr_mem [DEPTH];
    logic [`WB_DATA_W-1:0] data_mem [DEPTH];
    logic [1:0]            size_mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push = store_if.push;
    assign pop  = st_ack && (count != '0);  // ack on empty is dropped

    // entry payload, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= store_if.addr;
            data_mem[wr_ptr] <= store_if.data;
            size_mem[wr_ptr] <= store_if.size;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leave the count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    assign store_if.full = (count == CNT_W'(DEPTH));

    // head entry toward the memory port
    assign st_valid = (count != '0);
    assign st_addr  = addr_mem[rd_ptr];
    assign st_data  = data_mem[rd_ptr];
    assign st_size  = size_mem[rd_ptr];

endmodule

/* wb_top.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module wb_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_in,
    input  wb_pkg::wb_op_e                        op,
    input  logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0]  slot_data,
    input  logic [`WB_SLOTS-1:0][`WB_ADDR_W-1:0]  slot_dest,
    input  wb_pkg::slot_kind_e [`WB_SLOTS-1:0]    slot_kind,
    input  logic [`WB_SLOTS-1:0]                  slot_wb,
    input  logic [1:0]                            op_size,
    input  logic [3:0]                            size_ovr,
    input  logic [`WB_ADDR_W-1:0]                 eip_in,
    input  logic [`WB_EFLAGS_W-1:0]               eflags_in,
    input  logic                                  br_valid,
    input  logic                                  br_taken,
    input  logic                                  br_correct,
    input  logic [`WB_ADDR_W-1:0]                 br_target,
    input  logic                                  ie_in,
    input  wb_pkg::ie_type_e                      ie_type_in,
    input  logic                                  interrupt_in,
    input  logic [$clog2(`WB_NREGS)-1:0]          gpr_rd_addr,
    input  logic [$clog2(`WB_NREGS)-1:0]          seg_rd_addr,
    input  logic                                  st_ack,
    output logic                                  valid_out,
    output logic                                  stall,
    output logic                                  is_resteer,
    output logic                                  ie_val,
    output logic [3:0]                            ie_type_out,
    output logic [`WB_DATA_W-1:0]                 gpr_rd_data,
    output logic [`WB_SEG_W-1:0]                  seg_rd_data,
    output logic [`WB_ADDR_W-1:0]                 eip,
    output logic [`WB_SEG_W-1:0]                  cs,
    output logic [`WB_EFLAGS_W-1:0]               eflags,
    output logic                                  halted,
    output logic                                  st_valid,
    output logic [`WB_ADDR_W-1:0]                 st_addr,
    output logic [`WB_DATA_W-1:0]                 st_data,
    output logic [1:0]                            st_size
);

    wb_commit_if commit_bus ();
    wb_store_if  store_bus ();

    // combinational commit decision
    writeback_stage u_stage (
        .valid_in     (valid_in),     .op          (op),
        .slot_data    (slot_data),    .slot_dest   (slot_dest),
        .slot_kind    (slot_kind),    .slot_wb     (slot_wb),
        .op_size      (op_size),      .size_ovr    (size_ovr),
        .eip_in       (eip_in),       .eflags_in   (eflags_in),
        .br_valid     (br_valid),     .br_taken    (br_taken),
        .br_correct   (br_correct),   .br_target   (br_target),
        .ie_in        (ie_in),        .ie_type_in  (ie_type_in),
        .interrupt_in (interrupt_in),
        .commit_if    (commit_bus),   .store_if    (store_bus),
        .valid_out    (valid_out),    .stall       (stall),
        .is_resteer   (is_resteer),   .ie_val      (ie_val),
        .ie_type_out  (ie_type_out)
    );

    arch_state u_state (
        .clk         (clk),          .rst_n       (rst_n),
        .commit_if   (commit_bus),
        .gpr_rd_addr (gpr_rd_addr),  .seg_rd_addr (seg_rd_addr),
        .gpr_rd_data (gpr_rd_data),  .seg_rd_data (seg_rd_data),
        .eip         (eip),          .cs          (cs),
        .eflags      (eflags),       .halted      (halted)
    );

    // drained by the memory port through st_ack
    wb_store_queue u_queue (
        .clk      (clk),       .rst_n    (rst_n),
        .store_if (store_bus), .st_ack   (st_ack),
        .st_valid (st_valid),  .st_addr  (st_addr),
        .st_data  (st_data),   .st_size  (st_size)
    );

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps
`include "wb_consts.svh"

module writeback_stage (
    input  logic                                  valid_in,
    input  wb_pkg::wb_op_e                        op,
    input  logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0]  slot_data,
    input  logic [`WB_SLOTS-1:0][`WB_ADDR_W-1:0]  slot_dest,
    input  wb_pkg::slot_kind_e [`WB_SLOTS-1:0]    slot_kind,
    input  logic [`WB_SLOTS-1:0]                  slot_wb,
    input  logic [1:0]                            op_size,
    input  logic [3:0]                            size_ovr,   // one-hot
    input  logic [`WB_ADDR_W-1:0]                 eip_in,
    input  logic [`WB_EFLAGS_W-1:0]               eflags_in,
    input  logic                                  br_valid,
    input  logic                                  br_taken,
    input  logic                                  br_correct,
    input  logic [`WB_ADDR_W-1:0]                 br_target,
    input  logic                                  ie_in,
    input  wb_pkg::ie_type_e                      ie_type_in,
    input  logic                                  interrupt_in,
    wb_commit_if.stage                            commit_if,
    wb_store_if.stage                             store_if,
    output logic                                  valid_out,
    output logic                                  stall,
    output logic                                  is_resteer,
    output logic                                  ie_val,
    output logic [3:0]                            ie_type_out
);
    import wb_pkg::*;

    localparam int IDX_W  = $clog2(`WB_NREGS);
    localparam int SLOT_W = $clog2(`WB_SLOTS);

    logic                    commit;
    logic                    eip_cs_op;
    logic                    has_mem;
    logic [`WB_SLOTS-1:0]    reg_wr;
    logic [`WB_SLOTS-1:0]    seg_wr;
    logic [`WB_SLOTS-1:0]    mem_wr;
    logic [SLOT_W-1:0]       mem_sel;
    logic [1:0]              mem_size;
    logic [`WB_ADDR_W-1:0]   taken_eip;

    assign eip_cs_op = (op == op_far_jmp) || (op == op_far_call) || (op == op_iret);

    // per-slot destination decode, not yet qualified by commit
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            reg_wr[i] = slot_wb[i] && (slot_kind[i] == sk_reg);
            seg_wr[i] = slot_wb[i] && (slot_kind[i] == sk_seg);
            mem_wr[i] = slot_wb[i] && (slot_kind[i] == sk_mem);
        end
    end

    // hold the instruction while the address queue has no room
    assign has_mem   = valid_in && (|mem_wr);
    assign stall     = has_mem && store_if.full;
    assign commit    = valid_in && !stall;
    assign valid_out = commit;

    // lowest-numbered memory slot wins
    always_comb begin
        mem_sel = '0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (mem_wr[i])
                mem_sel = SLOT_W'(i);
        end
    end

    // size priority: override bit, then far transfer, then op size
    always_comb begin
        mem_size = op_size;
        if (eip_cs_op)
            mem_size = 2'd3;  // 8-byte EIP:CS image
        for (int i = 3; i >= 0; i--) begin
            if (size_ovr[i])
                mem_size = 2'(i);
        end
    end

    assign store_if.push = commit && (|mem_wr);
    assign store_if.addr = slot_dest[mem_sel];
    assign store_if.data = slot_data[mem_sel];
    assign store_if.size = mem_size;

    // register and segment commits
    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            commit_if.idx[i]  = slot_dest[i][IDX_W-1:0];
            commit_if.data[i] = slot_data[i];
        end
    end

    assign commit_if.reg_ld = reg_wr & {`WB_SLOTS{commit}};
    assign commit_if.seg_ld = seg_wr & {`WB_SLOTS{commit}};
    assign commit_if.commit = commit;

    // far transfers carry the target as {cs, eip} in slot 0
    assign taken_eip         = eip_cs_op ? slot_data[0][`WB_ADDR_W-1:0] : br_target;
    assign commit_if.new_eip = br_taken ? taken_eip : eip_in;
    assign commit_if.ld_cs   = eip_cs_op;
    assign commit_if.new_cs  = slot_data[0][47:32];
    assign commit_if.eflags  = eflags_in;
    assign commit_if.halt_set = commit && (op == op_halt);

    // mispredict only counts on a retiring instruction
    assign is_resteer = commit && br_valid && !br_correct;

    // interrupt/exception report
    assign ie_val      = valid_in && (ie_in || interrupt_in);
    assign ie_type_out = valid_in ? {interrupt_in, ie_type_in} : 4'd0;

endmodule
